// File: logic/spw_rx_pkg.sv
// Receiver types, control and state enums, register map, status bits and FIFO sizing
package spw_rx_pkg;

	// ----------------------------------------------------------
	// Sizes
	// ----------------------------------------------------------
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_LVL_W = $clog2(FIFO_DEPTH + 1); // Must hold FIFO_DEPTH itself

	typedef logic [8:0] data_flag_t;             // Bit 8 marks EOP or EEP
	typedef logic [7:0] time_code_t;             // Count plus two flags, as received
	typedef logic [FIFO_LVL_W-1:0] fifo_lvl_t;
	typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
	typedef logic [1:0] wb_adr_t;                // Word address
	typedef logic [31:0] wb_dat_t;

	localparam data_flag_t FLAG_EOP = 9'h100;
	localparam data_flag_t FLAG_EEP = 9'h101;

	// ESC flag and payload, then FCT parity, flag and payload, first bit in MSB
	localparam logic [6:0] NULL_BITS = 7'b1110100;

	// Two control bits after the flag, first arrival in the MSB
	typedef enum logic [1:0] {FCT = 2'd0, EOP = 2'd1, EEP = 2'd2, ESC = 2'd3} ctrl_code_t;

	typedef enum logic [1:0] {HUNT, FLAG, CTRL, DATA} char_state_t;

	// ----------------------------------------------------------
	// Links between blocks and the bus
	// ----------------------------------------------------------
	typedef struct packed {
		logic strobe;  // One cycle per received bit
		logic value;
	} rx_bit_t;

	typedef struct packed {
		logic       valid;
		data_flag_t data;
	} rx_char_t;

	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	typedef struct packed {
		logic    ack;
		wb_dat_t dat;
	} wb_rsp_t;

	// Register map
	localparam wb_adr_t ADR_DATA   = 2'd0;
	localparam wb_adr_t ADR_STATUS = 2'd1;
	localparam wb_adr_t ADR_TIME   = 2'd2;
	localparam wb_adr_t ADR_FCT    = 2'd3;

	// STATUS bits, level sits in the low bits
	localparam int STAT_EMPTY  = 5;
	localparam int STAT_FULL   = 6;
	localparam int STAT_LOCKED = 7;
	localparam int STAT_ERROR  = 8;
	localparam int STAT_OVF    = 9;
	localparam int STAT_TICK   = 10;
	localparam int DATA_EMPTY  = 31; // Set in a DATA read that found the FIFO empty

endpackage

// File: logic/spw_ds_sampler.sv
// Data-strobe input synchronizer and bit strobe generator
`timescale 1ns/1ps

module spw_ds_sampler (
	input  logic                negedge_clk,
	input  logic                rx_resetn,
	input  logic                rx_din,
	input  logic                rx_sin,
	output spw_rx_pkg::rx_bit_t rx_bit
);

	logic [1:0] d_sync;  // [1] is the settled copy
	logic [1:0] s_sync;
	logic       prev_x;  // Last D xor S
	logic       cur_x;
	logic       edge_seen;

	// Every bit flips exactly one of D and S, so D xor S toggles once per bit
	assign cur_x = d_sync[1] ^ s_sync[1];
	assign edge_seen = cur_x ^ prev_x;

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			d_sync <= 2'b00;
			s_sync <= 2'b00;
			prev_x <= 1'b0;   // Idle lines are both low
			rx_bit <= '0;
		end
		else
		begin
			// Two-flop synchronizers
			d_sync <= {d_sync[0], rx_din};
			s_sync <= {s_sync[0], rx_sin};

			prev_x <= cur_x;

			rx_bit.strobe <= edge_seen;
			rx_bit.value  <= d_sync[1]; // D carries the bit value
		end
	end

endmodule

// File: logic/spw_rx_char.sv
// Character framing, decoding and parity checking for the SpaceWire receiver
`timescale 1ns/1ps

module spw_rx_char (
	input  logic                   negedge_clk,
	input  logic                   rx_resetn,
	input  spw_rx_pkg::rx_bit_t    rx_bit,
	output spw_rx_pkg::rx_char_t   rx_char,
	output spw_rx_pkg::time_code_t rx_time_out,
	output logic                   rx_tick_out,
	output logic                   rx_got_fct,
	output logic                   rx_error,
	output logic                   locked
);

	spw_rx_pkg::char_state_t state;
	logic [6:0]              hunt_sr;  // Recent bits while hunting for NULL
	logic [7:0]              shift;    // Payload shifter, newest bit in MSB
	logic [2:0]              bit_cnt;
	logic                    par_bit;  // Parity bit of the current character
	logic                    par_acc;  // Running xor of the current payload
	logic                    prev_par; // Xor of the previous payload
	logic                    esc_pend;

	logic                    b;
	logic [6:0]              hunt_next;
	spw_rx_pkg::ctrl_code_t  code;
	logic [7:0]              rx_byte;

	assign b = rx_bit.value;
	assign hunt_next = {hunt_sr[5:0], b};
	assign code = spw_rx_pkg::ctrl_code_t'({shift[7], b});
	assign rx_byte = {b, shift[7:1]}; // LSB arrived first
	assign locked = (state != spw_rx_pkg::HUNT);

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			state       <= spw_rx_pkg::HUNT;
			hunt_sr     <= '0;
			shift       <= '0;
			bit_cnt     <= '0;
			par_bit     <= 1'b0;
			par_acc     <= 1'b0;
			prev_par    <= 1'b0;
			esc_pend    <= 1'b0;
			rx_char     <= '0;
			rx_time_out <= '0;
			rx_tick_out <= 1'b0;
			rx_got_fct  <= 1'b0;
			rx_error    <= 1'b0;
		end
		else
		begin
			// Pulses last one cycle
			rx_char.valid <= 1'b0;
			rx_tick_out   <= 1'b0;
			rx_got_fct    <= 1'b0;
			rx_error      <= 1'b0;

			if (rx_bit.strobe)
			begin
				case (state)
					spw_rx_pkg::HUNT:
					begin
						hunt_sr <= hunt_next;
						if (hunt_next == spw_rx_pkg::NULL_BITS)
						begin
							state    <= spw_rx_pkg::FLAG;
							bit_cnt  <= '0;
							prev_par <= 1'b0; // FCT payload is 00
							esc_pend <= 1'b0;
						end
					end
					spw_rx_pkg::FLAG:
					begin
						if (bit_cnt == 3'd0)
						begin
							par_bit <= b;
							bit_cnt <= 3'd1;
						end
						else if (!(prev_par ^ par_bit ^ b)) // Even group
						begin
							rx_error <= 1'b1;
							state    <= spw_rx_pkg::HUNT;
							hunt_sr  <= '0;
						end
						else
						begin
							state   <= b ? spw_rx_pkg::CTRL : spw_rx_pkg::DATA;
							bit_cnt <= '0;
							par_acc <= 1'b0;
						end
					end
					spw_rx_pkg::CTRL:
					begin
						shift   <= {b, shift[7:1]};
						par_acc <= par_acc ^ b;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd1)
						begin
							bit_cnt  <= '0;
							prev_par <= par_acc ^ b;
							state    <= spw_rx_pkg::FLAG;
							if (esc_pend)
							begin
								esc_pend <= 1'b0;
								if (code != spw_rx_pkg::FCT) // Only NULL may pair with ESC
								begin
									rx_error <= 1'b1;
									state    <= spw_rx_pkg::HUNT;
									hunt_sr  <= '0;
								end
							end
							else
							begin
								case (code)
									spw_rx_pkg::FCT: rx_got_fct <= 1'b1;
									spw_rx_pkg::EOP:
									begin
										rx_char.valid <= 1'b1;
										rx_char.data  <= spw_rx_pkg::FLAG_EOP;
									end
									spw_rx_pkg::EEP:
									begin
										rx_char.valid <= 1'b1;
										rx_char.data  <= spw_rx_pkg::FLAG_EEP;
									end
									default: esc_pend <= 1'b1;
								endcase
							end
						end
					end
					spw_rx_pkg::DATA:
					begin
						shift   <= {b, shift[7:1]};
						par_acc <= par_acc ^ b;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
						begin
							prev_par <= par_acc ^ b;
							state    <= spw_rx_pkg::FLAG;
							if (esc_pend)
							begin
								// ESC plus data is a time code
								esc_pend    <= 1'b0;
								rx_time_out <= rx_byte;
								rx_tick_out <= 1'b1;
							end
							else
							begin
								rx_char.valid <= 1'b1;
								rx_char.data  <= {1'b0, rx_byte};
							end
						end
					end
					default: state <= spw_rx_pkg::HUNT;
				endcase
			end
		end
	end

endmodule

// File: logic/spw_rx_fifo.sv
// Receive FIFO of data flags with sticky overflow
`timescale 1ns/1ps

module spw_rx_fifo (
	input  logic                   negedge_clk,
	input  logic                   rx_resetn,
	input  spw_rx_pkg::rx_char_t   rx_char,
	input  logic                   pop,
	input  logic                   ovf_clear,
	output spw_rx_pkg::data_flag_t head,
	output spw_rx_pkg::fifo_lvl_t  level,
	output logic                   overflow
);

	spw_rx_pkg::data_flag_t mem [spw_rx_pkg::FIFO_DEPTH];
	spw_rx_pkg::fifo_ptr_t  wr_ptr;
	spw_rx_pkg::fifo_ptr_t  rd_ptr;
	logic                   full;
	logic                   empty;
	logic                   push;
	logic                   do_pop;

	assign full   = (level == spw_rx_pkg::fifo_lvl_t'(spw_rx_pkg::FIFO_DEPTH));
	assign empty  = (level == '0);
	assign push   = rx_char.valid && !full;   // Dropped when full
	assign do_pop = pop && !empty;
	assign head   = mem[rd_ptr];

	always_ff @(posedge negedge_clk)
	begin
		if (push)
			mem[wr_ptr] <= rx_char.data;
	end

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			level    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			// Pointers wrap naturally, depth is a power of two
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;    // Idle, or push and pop together
			endcase

			if (rx_char.valid && full)
				overflow <= 1'b1;
			else if (ovf_clear)
				overflow <= 1'b0;
		end
	end

endmodule

// File: logic/spw_rx_wb_slave.sv
// Wishbone classic register port for received data, status, time code and FCT count
`timescale 1ns/1ps

module spw_rx_wb_slave (
	input  logic                   negedge_clk,
	input  logic                   rx_resetn,
	input  spw_rx_pkg::wb_req_t    wb_req,
	output spw_rx_pkg::wb_rsp_t    wb_rsp,
	input  spw_rx_pkg::data_flag_t head,
	input  spw_rx_pkg::fifo_lvl_t  level,
	input  logic                   overflow,
	output logic                   pop,
	output logic                   ovf_clear,
	input  spw_rx_pkg::time_code_t time_code,
	input  logic                   tick,
	input  logic                   got_fct,
	input  logic                   error,
	input  logic                   locked
);

	logic                ack_q;
	spw_rx_pkg::wb_dat_t dat_q;
	spw_rx_pkg::wb_dat_t rd_dat;
	logic                req_new;
	logic                status_wr;
	logic                empty;
	logic                full;
	logic                err_flag;
	logic                tick_flag;
	logic [7:0]          fct_cnt;

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = dat_q;

	// A request counts once, ack masks the second cycle of stb
	assign req_new   = wb_req.cyc && wb_req.stb && !ack_q;
	assign status_wr = req_new && wb_req.we && (wb_req.adr == spw_rx_pkg::ADR_STATUS);
	assign empty     = (level == '0);
	assign full      = (level == spw_rx_pkg::fifo_lvl_t'(spw_rx_pkg::FIFO_DEPTH));

	// ----------------------------------------------------------
	// Read mux
	// ----------------------------------------------------------
	always_comb
	begin
		rd_dat = '0;
		case (wb_req.adr)
			spw_rx_pkg::ADR_DATA:
			begin
				if (empty)
					rd_dat[spw_rx_pkg::DATA_EMPTY] = 1'b1;
				else
					rd_dat[8:0] = head;
			end
			spw_rx_pkg::ADR_STATUS:
			begin
				rd_dat[spw_rx_pkg::FIFO_LVL_W-1:0] = level;
				rd_dat[spw_rx_pkg::STAT_EMPTY]     = empty;
				rd_dat[spw_rx_pkg::STAT_FULL]      = full;
				rd_dat[spw_rx_pkg::STAT_LOCKED]    = locked;
				rd_dat[spw_rx_pkg::STAT_ERROR]     = err_flag;
				rd_dat[spw_rx_pkg::STAT_OVF]       = overflow;
				rd_dat[spw_rx_pkg::STAT_TICK]      = tick_flag;
			end
			spw_rx_pkg::ADR_TIME: rd_dat[7:0] = time_code;
			spw_rx_pkg::ADR_FCT:  rd_dat[7:0] = fct_cnt;
			default:              rd_dat = '0;
		endcase
	end

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			ack_q     <= 1'b0;
			pop       <= 1'b0;
			ovf_clear <= 1'b0;
			err_flag  <= 1'b0;
			tick_flag <= 1'b0;
			fct_cnt   <= '0;
		end
		else
		begin
			ack_q     <= req_new;
			// Pop lands with ack, FIFO advances on the next edge
			pop       <= req_new && !wb_req.we && (wb_req.adr == spw_rx_pkg::ADR_DATA) && !empty;
			ovf_clear <= status_wr;

			// New events win over a clear in the same cycle
			if (error)
				err_flag <= 1'b1;
			else if (status_wr)
				err_flag <= 1'b0;

			if (tick)
				tick_flag <= 1'b1;
			else if (status_wr)
				tick_flag <= 1'b0;

			if (got_fct)
				fct_cnt <= fct_cnt + 8'd1; // Wraps
		end
	end

	always_ff @(posedge negedge_clk)
	begin
		if (req_new && !wb_req.we)
			dat_q <= rd_dat;
	end

endmodule

// File: logic/spw_rx_top.sv
// SpaceWire receiver top level with sampler, decoder, FIFO and Wishbone port
`timescale 1ns/1ps

module spw_rx_top (
	input  logic                   negedge_clk,
	input  logic                   rx_resetn,
	input  logic                   rx_din,
	input  logic                   rx_sin,
	input  spw_rx_pkg::wb_req_t    wb_req,
	output spw_rx_pkg::wb_rsp_t    wb_rsp,
	output spw_rx_pkg::time_code_t rx_time_out,
	output logic                   rx_tick_out,
	output logic                   rx_got_fct,
	output logic                   rx_error
);

	spw_rx_pkg::rx_bit_t    rx_bit;
	spw_rx_pkg::rx_char_t   rx_char;
	spw_rx_pkg::data_flag_t head;
	spw_rx_pkg::fifo_lvl_t  level;
	logic                   overflow;
	logic                   pop;
	logic                   ovf_clear;
	logic                   locked;

	spw_ds_sampler i_sampler (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.rx_bit      (rx_bit)
	);

	spw_rx_char i_char (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_bit      (rx_bit),
		.rx_char     (rx_char),
		.rx_time_out (rx_time_out),
		.rx_tick_out (rx_tick_out),
		.rx_got_fct  (rx_got_fct),
		.rx_error    (rx_error),
		.locked      (locked)
	);

	spw_rx_fifo i_fifo (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_char     (rx_char),
		.pop         (pop),
		.ovf_clear   (ovf_clear),
		.head        (head),
		.level       (level),
		.overflow    (overflow)
	);

	// Host side, also sees the decoder events for its sticky flags
	spw_rx_wb_slave i_wb (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.head        (head),
		.level       (level),
		.overflow    (overflow),
		.pop         (pop),
		.ovf_clear   (ovf_clear),
		.time_code   (rx_time_out),
		.tick        (rx_tick_out),
		.got_fct     (rx_got_fct),
		.error       (rx_error),
		.locked      (locked)
	);

endmodule

// File: tb/spw_rx_assert.sv
// Bound assertions on the Wishbone ack handshake and the FIFO pop pulse
`timescale 1ns/1ps

module spw_rx_assert (
	input logic                clk,
	input logic                rst_n,
	input spw_rx_pkg::wb_req_t wb_req,
	input spw_rx_pkg::wb_rsp_t wb_rsp,
	input logic                pop
);

	int fail_count = 0;  // Failed assertions so far

	// ack is a one-cycle pulse
	property ack_single;
		@(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack;
	endproperty

	// ack answers a request seen on the previous edge
	property ack_after_req;
		@(posedge clk) disable iff (!rst_n) wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb);
	endproperty

	property pop_single;
		@(posedge clk) disable iff (!rst_n) pop |=> !pop;
	endproperty

	a_ack_single: assert property (ack_single)
	else
	begin
		fail_count++;
		$error("ack high for two cycles");
	end

	a_ack_after_req: assert property (ack_after_req)
	else
	begin
		fail_count++;
		$error("ack without cyc and stb");
	end

	a_pop_single: assert property (pop_single)
	else
	begin
		fail_count++;
		$error("pop high for two cycles");
	end

endmodule

bind spw_rx_wb_slave spw_rx_assert i_assert (
	.clk    (negedge_clk),
	.rst_n  (rx_resetn),
	.wb_req (wb_req),
	.wb_rsp (wb_rsp),
	.pop    (pop)
);

// File: tb/spw_rx_checker.sv
// Testbench checker with expected-value model, expected queues and comparison of reads and ticks
`timescale 1ns/1ps

module spw_rx_checker (
	input logic                   negedge_clk,
	input logic                   rx_resetn,
	input spw_rx_pkg::wb_req_t    wb_req,
	input spw_rx_pkg::wb_rsp_t    wb_rsp,
	input spw_rx_pkg::time_code_t rx_time_out,
	input logic                   rx_tick_out,
	input logic                   rx_got_fct,
	input logic                   rx_error
);

	int                     errors = 0;
	int                     checks = 0;
	int                     tick_count = 0;
	int                     fct_count = 0;
	int                     err_count = 0;
	logic [31:0]            exp_data [$];   // DATA register words in order
	spw_rx_pkg::time_code_t exp_time [$];
	spw_rx_pkg::time_code_t last_time = '0;
	logic [7:0]             exp_fct = '0;

	// Expected DATA word for a sent character
	function automatic logic [31:0] data_word(input logic ctrl, input logic [7:0] payload);
		if (!ctrl)
			return {24'h0, payload};
		else if (payload[1:0] == 2'd1)
			return 32'h100;  // EOP
		else
			return 32'h101;  // EEP
	endfunction

	task automatic expect_char(input logic ctrl, input logic [7:0] payload);
		exp_data.push_back(data_word(ctrl, payload));
	endtask

	task automatic expect_time(input spw_rx_pkg::time_code_t tc);
		exp_time.push_back(tc);
	endtask

	task automatic expect_fct();
		exp_fct = exp_fct + 8'd1;  // 8-bit wrap like the register
	endtask

	task automatic note_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_read(input spw_rx_pkg::wb_adr_t adr, input logic [31:0] dat);
		logic [31:0] want;
		case (adr)
			spw_rx_pkg::ADR_DATA:
			begin
				if (exp_data.size() > 0)
					want = exp_data.pop_front();
				else
					want = 32'h8000_0000;  // Empty marker only
				compare("wb_rsp.dat DATA", dat, want);
			end
			spw_rx_pkg::ADR_TIME: compare("wb_rsp.dat TIME", dat, {24'h0, last_time});
			spw_rx_pkg::ADR_FCT:  compare("wb_rsp.dat FCT", dat, {24'h0, exp_fct});
			default: ;  // STATUS compared field by field by the stimulus side
		endcase
	endtask

	// ----------------------------------------------------------
	// Monitor, samples mid-cycle
	// ----------------------------------------------------------
	always @(negedge negedge_clk)
	begin
		if (rx_resetn)
		begin
			if (wb_rsp.ack && wb_req.cyc && wb_req.stb && !wb_req.we)
				check_read(wb_req.adr, wb_rsp.dat);
			if (rx_tick_out)
			begin
				tick_count++;
				if (exp_time.size() == 0)
					note_error("tick on rx_tick_out with no time code sent");
				else
				begin
					last_time = exp_time.pop_front();
					compare("rx_time_out", rx_time_out, last_time);
				end
			end
			if (rx_got_fct)
				fct_count++;
			if (rx_error)
				err_count++;
		end
	end

endmodule

// File: tb/spw_rx_tb.sv
// Testbench top with clock, reset, data-strobe encoder, Wishbone master tasks and run summary
`timescale 1ns/1ps

module spw_rx_tb;

	localparam int ACK_LIMIT  = 20;
	localparam int POLL_LIMIT = 50;
	localparam int EVT_LIMIT  = 200;

	logic                   negedge_clk;
	logic                   rx_resetn;
	logic                   rx_din;
	logic                   rx_sin;
	spw_rx_pkg::wb_req_t    wb_req;
	spw_rx_pkg::wb_rsp_t    wb_rsp;
	spw_rx_pkg::time_code_t rx_time_out;
	logic                   rx_tick_out;
	logic                   rx_got_fct;
	logic                   rx_error;
	logic                   prev_par;  // Payload parity of the last character sent

	spw_rx_top i_dut (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.rx_time_out (rx_time_out),
		.rx_tick_out (rx_tick_out),
		.rx_got_fct  (rx_got_fct),
		.rx_error    (rx_error)
	);

	spw_rx_checker i_chk (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.rx_time_out (rx_time_out),
		.rx_tick_out (rx_tick_out),
		.rx_got_fct  (rx_got_fct),
		.rx_error    (rx_error)
	);

	initial
		negedge_clk = 1'b0;
	always #4 negedge_clk = ~negedge_clk;

	// Character bits in send order with odd parity over prev payload, P and flag
	function automatic logic [9:0] char_bits(input logic ctrl, input logic [7:0] payload,
		input logic last_par);
		logic [9:0] bits;
		bits = '0;
		bits[0] = 1'b1 ^ last_par ^ ctrl;
		bits[1] = ctrl;
		if (ctrl)
		begin
			bits[2] = payload[1];  // Code MSB goes first
			bits[3] = payload[0];
		end
		else
			bits[9:2] = payload;   // LSB first
		return bits;
	endfunction

	// ----------------------------------------------------------
	// Every task starts and ends 1 ns after a rising edge
	// ----------------------------------------------------------
	task automatic send_bit(input logic b);
		if (b != rx_din)
			rx_din = b;
		else
			rx_sin = ~rx_sin;  // Strobe flips when data repeats
		repeat (4) @(posedge negedge_clk);
		#1;
	endtask

	task automatic send_char(input logic ctrl, input logic [7:0] payload, input logic bad);
		logic [9:0] bits;
		int         n;
		int         i;
		bits = char_bits(ctrl, payload, prev_par);
		bits[0] = bits[0] ^ bad;
		n = ctrl ? 4 : 10;
		for (i = 0; i < n; i++)
			send_bit(bits[i]);
		prev_par = ctrl ? ^payload[1:0] : ^payload;
	endtask

	task automatic send_null();
		send_char(1'b1, 8'd3, 1'b0);  // ESC
		send_char(1'b1, 8'd0, 1'b0);  // FCT
	endtask

	task automatic send_expected(input logic ctrl, input logic [7:0] payload);
		i_chk.expect_char(ctrl, payload);
		send_char(ctrl, payload, 1'b0);
	endtask

	task automatic finish_run();
		int asrt_fails;
		asrt_fails = i_dut.i_wb.i_assert.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", i_chk.checks, i_chk.errors,
			asrt_fails);
		if (i_chk.errors == 0 && asrt_fails == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	task automatic wb_access(input logic we, input spw_rx_pkg::wb_adr_t adr,
		input spw_rx_pkg::wb_dat_t wdat, output spw_rx_pkg::wb_dat_t rdat);
		int n;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		n = 0;
		@(posedge negedge_clk);
		#1;
		while (!wb_rsp.ack && n < ACK_LIMIT)
		begin
			@(posedge negedge_clk);
			#1;
			n++;
		end
		if (!wb_rsp.ack)
		begin
			i_chk.note_error("no Wishbone ack within the timeout");
			finish_run();
		end
		else
		begin
			rdat = wb_rsp.dat;
			@(posedge negedge_clk);  // stb held through the ack cycle
			#1;
			wb_req = '0;
		end
	endtask

	task automatic check_status(input int lvl, input logic locked, input logic err,
		input logic ovf, input logic tick);
		spw_rx_pkg::wb_dat_t st;
		wb_access(1'b0, spw_rx_pkg::ADR_STATUS, 32'h0, st);
		i_chk.compare("STATUS.level", st[spw_rx_pkg::FIFO_LVL_W-1:0], lvl);
		i_chk.compare("STATUS.empty", st[spw_rx_pkg::STAT_EMPTY], lvl == 0);
		i_chk.compare("STATUS.full", st[spw_rx_pkg::STAT_FULL], lvl == spw_rx_pkg::FIFO_DEPTH);
		i_chk.compare("STATUS.locked", st[spw_rx_pkg::STAT_LOCKED], locked);
		i_chk.compare("STATUS.error", st[spw_rx_pkg::STAT_ERROR], err);
		i_chk.compare("STATUS.overflow", st[spw_rx_pkg::STAT_OVF], ovf);
		i_chk.compare("STATUS.tick", st[spw_rx_pkg::STAT_TICK], tick);
	endtask

	task automatic wait_level(input int target);
		spw_rx_pkg::wb_dat_t st;
		int                  n;
		n = 0;
		wb_access(1'b0, spw_rx_pkg::ADR_STATUS, 32'h0, st);
		while (st[spw_rx_pkg::FIFO_LVL_W-1:0] != target && n < POLL_LIMIT)
		begin
			wb_access(1'b0, spw_rx_pkg::ADR_STATUS, 32'h0, st);
			n++;
		end
		if (st[spw_rx_pkg::FIFO_LVL_W-1:0] != target)
		begin
			i_chk.note_error($sformatf("FIFO level never reached %0d", target));
			finish_run();
		end
	endtask

	function automatic int event_count(input string what);
		case (what)
			"tick":  return i_chk.tick_count;
			"fct":   return i_chk.fct_count;
			default: return i_chk.err_count;
		endcase
	endfunction

	task automatic wait_event(input string what, input int target);
		int n;
		n = 0;
		while (event_count(what) < target && n < EVT_LIMIT)
		begin
			@(posedge negedge_clk);
			#1;
			n++;
		end
		if (event_count(what) < target)
		begin
			i_chk.note_error($sformatf("timeout waiting for %s pulse %0d", what, target));
			finish_run();
		end
	endtask

	initial
	begin
		logic [31:0]         rnd;
		spw_rx_pkg::wb_dat_t rd;
		int                  i;
		void'($urandom(32'hd700));
		rx_resetn = 1'b0;
		rx_din    = 1'b0;
		rx_sin    = 1'b0;
		wb_req    = '0;
		prev_par  = 1'b0;
		repeat (8) @(posedge negedge_clk);
		#1;
		rx_resetn = 1'b1;
		@(posedge negedge_clk);
		#1;

		// Reset state
		i_chk.compare("rx_time_out", rx_time_out, 32'h0);
		i_chk.compare("rx_tick_out", rx_tick_out, 32'h0);
		i_chk.compare("rx_got_fct", rx_got_fct, 32'h0);
		i_chk.compare("rx_error", rx_error, 32'h0);
		i_chk.compare("wb_rsp.ack", wb_rsp.ack, 32'h0);
		check_status(0, 1'b0, 1'b0, 1'b0, 1'b0);
		wb_access(1'b0, spw_rx_pkg::ADR_DATA, 32'h0, rd);

		// Lock then data with EOP and EEP
		repeat (3) send_null();
		check_status(0, 1'b1, 1'b0, 1'b0, 1'b0);
		for (i = 0; i < 6; i++)
		begin
			rnd = $urandom;
			send_expected(1'b0, rnd[7:0]);
		end
		send_expected(1'b1, 8'd1);
		for (i = 0; i < 3; i++)
		begin
			rnd = $urandom;
			send_expected(1'b0, rnd[7:0]);
		end
		send_expected(1'b1, 8'd2);
		wait_level(11);
		repeat (11) wb_access(1'b0, spw_rx_pkg::ADR_DATA, 32'h0, rd);

		// Time code and sticky tick
		rnd = $urandom;
		i_chk.expect_time(rnd[7:0]);
		send_char(1'b1, 8'd3, 1'b0);
		send_char(1'b0, rnd[7:0], 1'b0);
		wait_event("tick", 1);
		wb_access(1'b0, spw_rx_pkg::ADR_TIME, 32'h0, rd);
		check_status(0, 1'b1, 1'b0, 1'b0, 1'b1);
		wb_access(1'b1, spw_rx_pkg::ADR_STATUS, 32'h0, rd);
		check_status(0, 1'b1, 1'b0, 1'b0, 1'b0);

		// Flow-control tokens
		repeat (5)
		begin
			i_chk.expect_fct();
			send_char(1'b1, 8'd0, 1'b0);
		end
		wait_event("fct", 5);
		i_chk.compare("rx_got_fct pulses", i_chk.fct_count, 32'd5);
		wb_access(1'b0, spw_rx_pkg::ADR_FCT, 32'h0, rd);

		// Parity error drops lock and NULLs relock
		send_char(1'b0, 8'h00, 1'b1);
		wait_event("error", 1);
		check_status(0, 1'b0, 1'b1, 1'b0, 1'b0);
		repeat (2) send_null();
		check_status(0, 1'b1, 1'b1, 1'b0, 1'b0);
		wb_access(1'b1, spw_rx_pkg::ADR_STATUS, 32'h0, rd);
		for (i = 0; i < 3; i++)
		begin
			rnd = $urandom;
			send_expected(1'b0, rnd[7:0]);
		end
		send_expected(1'b1, 8'd1);
		wait_level(4);
		repeat (4) wb_access(1'b0, spw_rx_pkg::ADR_DATA, 32'h0, rd);
		check_status(0, 1'b1, 1'b0, 1'b0, 1'b0);
		i_chk.compare("rx_error pulses", i_chk.err_count, 32'd1);

		// Overflow keeps only the first 16 bytes
		for (i = 0; i < 20; i++)
		begin
			rnd = $urandom;
			if (i < spw_rx_pkg::FIFO_DEPTH)
				i_chk.expect_char(1'b0, rnd[7:0]);
			send_char(1'b0, rnd[7:0], 1'b0);
		end
		wait_level(spw_rx_pkg::FIFO_DEPTH);
		check_status(spw_rx_pkg::FIFO_DEPTH, 1'b1, 1'b0, 1'b1, 1'b0);
		repeat (17) wb_access(1'b0, spw_rx_pkg::ADR_DATA, 32'h0, rd);  // Last one finds it empty
		check_status(0, 1'b1, 1'b0, 1'b1, 1'b0);
		wb_access(1'b1, spw_rx_pkg::ADR_STATUS, 32'h0, rd);
		check_status(0, 1'b1, 1'b0, 1'b0, 1'b0);

		finish_run();
	end

endmodule

// File: all.f
logic/spw_rx_pkg.sv
logic/spw_ds_sampler.sv
logic/spw_rx_char.sv
logic/spw_rx_fifo.sv
logic/spw_rx_wb_slave.sv
logic/spw_rx_top.sv
tb/spw_rx_assert.sv
tb/spw_rx_checker.sv
tb/spw_rx_tb.sv

// File: Bender.yml
package:
  name: spw_rx

sources:
  # Receiver RTL, package first
  - logic/spw_rx_pkg.sv
  - logic/spw_ds_sampler.sv
  - logic/spw_rx_char.sv
  - logic/spw_rx_fifo.sv
  - logic/spw_rx_wb_slave.sv
  - logic/spw_rx_top.sv

  # Testbench
  - target: test
    files:
      - tb/spw_rx_assert.sv
      - tb/spw_rx_checker.sv
      - tb/spw_rx_tb.sv
